/* mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

  localparam int MEM_DATA_WIDTH = 64;
  localparam int MEM_BYTE_WIDTH = MEM_DATA_WIDTH / 8;
  localparam int UNIT_SIZE      = 2;  // 32-bit lanes per beat.
  localparam int LANE_WIDTH     = $clog2(UNIT_SIZE);
  localparam int MEM_ID_WIDTH   = 4;
  localparam int MEM_ADDR_WIDTH = 16;
  localparam int LENGTH_WIDTH   = 5;  // holds up to 16 units, zero is illegal.

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_cmd_e;

  typedef struct packed {
    mem_cmd_e                  kind;
    logic [MEM_ID_WIDTH-1:0]   id;
    logic [MEM_ADDR_WIDTH-1:0] addr;    // byte address of the first unit.
    logic [LENGTH_WIDTH-1:0]   length;  // number of 32-bit units.
  } mem_cmd_t;

  typedef struct packed {
    logic [MEM_DATA_WIDTH-1:0] data;
    logic [MEM_BYTE_WIDTH-1:0] byteen;
  } mem_wdata_t;

  typedef struct packed {
    logic [MEM_ID_WIDTH-1:0]   id;
    logic [MEM_DATA_WIDTH-1:0] data;
    logic                      error;
    logic                      last;
  } mem_resp_t;

  typedef struct packed {
    logic [MEM_ID_WIDTH-1:0] id;
    logic [LANE_WIDTH-1:0]   lane;    // lane of the first unit.
    logic [LENGTH_WIDTH-1:0] length;
  } resp_info_t;

endpackage

`default_nettype wire

/* csr_bus_pkg.sv */
`default_nettype none

package csr_bus_pkg;

  localparam int CSR_DATA_WIDTH = 32;
  localparam int UNIT_BYTES     = CSR_DATA_WIDTH / 8;
  localparam int CSR_ADDR_WIDTH = 16;

  typedef struct packed {
    logic                      write;
    logic [CSR_ADDR_WIDTH-1:0] addr;    // always word aligned.
    logic [CSR_DATA_WIDTH-1:0] data;
    logic [UNIT_BYTES-1:0]     byteen;
  } csr_cmd_t;

  typedef struct packed {
    logic [CSR_DATA_WIDTH-1:0] data;
    logic                      error;
  } csr_resp_t;

endpackage

`default_nettype wire

/* resp_info_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_info_fifo #(
  parameter int INFO_DEPTH = 4
) (
  input  var logic                    i_clk,
  input  var logic                    i_rst_n,
  input  var logic                    i_push,
  input  var mem_bus_pkg::resp_info_t i_data,
  input  var logic                    i_pop,
  output mem_bus_pkg::resp_info_t     o_data,
  output logic                        o_empty,
  output logic                        o_full
);

  localparam int PTR_WIDTH   = (INFO_DEPTH > 1) ? $clog2(INFO_DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(INFO_DEPTH + 1);

  mem_bus_pkg::resp_info_t entries [INFO_DEPTH];
  logic [PTR_WIDTH-1:0]    rd_ptr;
  logic [PTR_WIDTH-1:0]    wr_ptr;
  logic [COUNT_WIDTH-1:0]  count;
  logic                    push_en;
  logic                    pop_en;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(INFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_WIDTH'(1);
  endfunction

  always_comb begin
    o_empty = count == '0;
    o_full  = count == COUNT_WIDTH'(INFO_DEPTH);
    push_en = i_push && !o_full;
    pop_en  = i_pop && !o_empty;
    o_data  = entries[rd_ptr];  // head entry is always visible.
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push_en, pop_en})
        2'b10:   count <= count + COUNT_WIDTH'(1);
        2'b01:   count <= count - COUNT_WIDTH'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (push_en) begin
      entries[wr_ptr] <= i_data;
    end
  end

endmodule

`default_nettype wire

/* request_splitter.sv */
`timescale 1ns/1ps
`default_nettype none

module request_splitter (
  input  var logic                    i_clk,
  input  var logic                    i_rst_n,
  input  var logic                    i_mem_cmd_valid,
  input  var mem_bus_pkg::mem_cmd_t   i_mem_cmd,
  output logic                        o_mem_cmd_accept,
  input  var logic                    i_mem_wdata_valid,
  input  var mem_bus_pkg::mem_wdata_t i_mem_wdata,
  output logic                        o_mem_wdata_accept,
  output logic                        o_csr_cmd_valid,
  output csr_bus_pkg::csr_cmd_t       o_csr_cmd,
  input  var logic                    i_csr_cmd_accept,
  input  var logic                    i_info_full,
  output logic                        o_info_push,
  output mem_bus_pkg::resp_info_t     o_info
);

  localparam int UNIT_BYTES = csr_bus_pkg::UNIT_BYTES;
  localparam int UNIT_WIDTH = csr_bus_pkg::CSR_DATA_WIDTH;
  localparam int ADDR_WIDTH = csr_bus_pkg::CSR_ADDR_WIDTH;
  localparam int OFFSET_LSB = $clog2(UNIT_BYTES);
  localparam int LANE_WIDTH = mem_bus_pkg::LANE_WIDTH;
  localparam int LEN_WIDTH  = mem_bus_pkg::LENGTH_WIDTH;

  logic                  busy;
  logic [LEN_WIDTH-1:0]  remain;
  logic [LANE_WIDTH-1:0] lane;
  logic [ADDR_WIDTH-1:0] unit_addr;

  logic [LEN_WIDTH-1:0]  cur_len;
  logic [LANE_WIDTH-1:0] cur_lane;
  logic [ADDR_WIDTH-1:0] cur_addr;
  logic                  is_write;
  logic                  last_unit;
  logic                  last_lane;
  logic [UNIT_BYTES-1:0] unit_byteen;
  logic [UNIT_WIDTH-1:0] unit_data;
  logic                  skip;
  logic                  read_go;
  logic                  write_go;
  logic                  step;

  // the first unit comes straight from the command, later units from the counters.
  always_comb begin
    if (busy) begin
      cur_len  = remain;
      cur_lane = lane;
      cur_addr = unit_addr;
    end else begin
      cur_len  = i_mem_cmd.length;
      cur_lane = i_mem_cmd.addr[OFFSET_LSB +: LANE_WIDTH];
      cur_addr = ADDR_WIDTH'(i_mem_cmd.addr) & ~ADDR_WIDTH'(UNIT_BYTES - 1);
    end
  end

  always_comb begin
    is_write    = i_mem_cmd.kind == mem_bus_pkg::MEM_WRITE;
    last_unit   = cur_len == LEN_WIDTH'(1);
    last_lane   = cur_lane == LANE_WIDTH'(mem_bus_pkg::UNIT_SIZE - 1);
    unit_byteen = i_mem_wdata.byteen[UNIT_BYTES*cur_lane +: UNIT_BYTES];
    unit_data   = i_mem_wdata.data[UNIT_WIDTH*cur_lane +: UNIT_WIDTH];
    skip        = unit_byteen == '0;
    read_go     = i_mem_cmd_valid && !is_write && (busy || !i_info_full);
    write_go    = i_mem_cmd_valid && is_write && i_mem_wdata_valid;
    step        = (read_go && i_csr_cmd_accept) ||
                  (write_go && (skip || i_csr_cmd_accept));  // a skipped unit still takes a cycle.
  end

  always_comb begin
    o_csr_cmd_valid    = read_go || (write_go && !skip);
    o_csr_cmd.write    = is_write;
    o_csr_cmd.addr     = cur_addr;
    o_csr_cmd.data     = is_write ? unit_data : '0;
    o_csr_cmd.byteen   = is_write ? unit_byteen : '0;
    o_mem_cmd_accept   = step && last_unit;
    o_mem_wdata_accept = write_go && step && (last_lane || last_unit);
  end

  // a read is recorded once, with its first unit.
  always_comb begin
    o_info_push   = read_go && step && !busy;
    o_info.id     = i_mem_cmd.id;
    o_info.lane   = i_mem_cmd.addr[OFFSET_LSB +: LANE_WIDTH];
    o_info.length = i_mem_cmd.length;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy      <= 1'b0;
      remain    <= '0;
      lane      <= '0;
      unit_addr <= '0;
    end else if (step) begin
      busy      <= !last_unit;
      remain    <= cur_len - LEN_WIDTH'(1);
      lane      <= cur_lane + LANE_WIDTH'(1);
      unit_addr <= cur_addr + ADDR_WIDTH'(UNIT_BYTES);
    end
  end

endmodule

`default_nettype wire

/* response_merger.sv */
`timescale 1ns/1ps
`default_nettype none

module response_merger (
  input  var logic                    i_clk,
  input  var logic                    i_rst_n,
  input  var logic                    i_csr_resp_valid,
  input  var csr_bus_pkg::csr_resp_t  i_csr_resp,
  output logic                        o_csr_resp_accept,
  output logic                        o_mem_resp_valid,
  output mem_bus_pkg::mem_resp_t      o_mem_resp,
  input  var logic                    i_mem_resp_accept,
  input  var mem_bus_pkg::resp_info_t i_info,
  input  var logic                    i_info_empty,
  output logic                        o_info_pop
);

  localparam int UNIT_WIDTH = csr_bus_pkg::CSR_DATA_WIDTH;
  localparam int UNIT_SIZE  = mem_bus_pkg::UNIT_SIZE;
  localparam int LANE_WIDTH = mem_bus_pkg::LANE_WIDTH;
  localparam int LEN_WIDTH  = mem_bus_pkg::LENGTH_WIDTH;
  localparam int DATA_WIDTH = mem_bus_pkg::MEM_DATA_WIDTH;

  logic [LEN_WIDTH-1:0]                 count;
  logic [LANE_WIDTH-1:0]                lane;
  logic [UNIT_SIZE-2:0][UNIT_WIDTH-1:0] lane_data;
  logic                                 error;

  logic [LANE_WIDTH-1:0]                cur_lane;
  logic                                 last_unit;
  logic                                 send;
  logic                                 csr_ack;
  logic [DATA_WIDTH-1:0]                beat_data;

  always_comb begin
    cur_lane  = (count == '0) ? i_info.lane : lane;
    last_unit = (count + LEN_WIDTH'(1)) == i_info.length;
    send      = last_unit || (cur_lane == LANE_WIDTH'(UNIT_SIZE - 1));

    o_mem_resp_valid  = i_csr_resp_valid && !i_info_empty && send;
    o_csr_resp_accept = !i_info_empty && (!send || i_mem_resp_accept);
    csr_ack           = i_csr_resp_valid && o_csr_resp_accept;
    o_info_pop        = csr_ack && last_unit;
  end

  // lanes not yet written in this beat hold zero, so uncovered lanes read zero.
  always_comb begin
    beat_data = '0;
    for (int i = 0; i < UNIT_SIZE - 1; i++) begin
      beat_data[UNIT_WIDTH*i +: UNIT_WIDTH] = lane_data[i];
    end
    beat_data[UNIT_WIDTH*cur_lane +: UNIT_WIDTH] = i_csr_resp.data;
  end

  always_comb begin
    o_mem_resp.id    = i_info.id;
    o_mem_resp.data  = beat_data;
    o_mem_resp.error = error || i_csr_resp.error;
    o_mem_resp.last  = last_unit;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count <= '0;
      lane  <= '0;
    end else if (csr_ack) begin
      count <= last_unit ? '0 : count + LEN_WIDTH'(1);
      lane  <= cur_lane + LANE_WIDTH'(1);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lane_data <= '0;
      error     <= 1'b0;
    end else if (csr_ack) begin
      if (send) begin
        lane_data <= '0;
        error     <= 1'b0;
      end else begin
        for (int i = 0; i < UNIT_SIZE - 1; i++) begin
          if (LANE_WIDTH'(i) == cur_lane) begin
            lane_data[i] <= i_csr_resp.data;
          end
        end
        error <= error || i_csr_resp.error;  // sticky until the beat goes out.
      end
    end
  end

endmodule

`default_nettype wire

/* membus2csr_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module membus2csr_bridge #(
  parameter int INFO_DEPTH = 4
) (
  input  var logic                    i_clk,
  input  var logic                    i_rst_n,
  input  var logic                    i_mem_cmd_valid,
  input  var mem_bus_pkg::mem_cmd_t   i_mem_cmd,
  output logic                        o_mem_cmd_accept,
  input  var logic                    i_mem_wdata_valid,
  input  var mem_bus_pkg::mem_wdata_t i_mem_wdata,
  output logic                        o_mem_wdata_accept,
  output logic                        o_mem_resp_valid,
  output mem_bus_pkg::mem_resp_t      o_mem_resp,
  input  var logic                    i_mem_resp_accept,
  output logic                        o_csr_cmd_valid,
  output csr_bus_pkg::csr_cmd_t       o_csr_cmd,
  input  var logic                    i_csr_cmd_accept,
  input  var logic                    i_csr_resp_valid,
  input  var csr_bus_pkg::csr_resp_t  i_csr_resp,
  output logic                        o_csr_resp_accept
);

  logic                    info_push;
  logic                    info_pop;
  logic                    info_empty;
  logic                    info_full;
  mem_bus_pkg::resp_info_t info_in;
  mem_bus_pkg::resp_info_t info_head;

  request_splitter u_splitter (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_mem_cmd_valid    (i_mem_cmd_valid),
    .i_mem_cmd          (i_mem_cmd),
    .o_mem_cmd_accept   (o_mem_cmd_accept),
    .i_mem_wdata_valid  (i_mem_wdata_valid),
    .i_mem_wdata        (i_mem_wdata),
    .o_mem_wdata_accept (o_mem_wdata_accept),
    .o_csr_cmd_valid    (o_csr_cmd_valid),
    .o_csr_cmd          (o_csr_cmd),
    .i_csr_cmd_accept   (i_csr_cmd_accept),
    .i_info_full        (info_full),
    .o_info_push        (info_push),
    .o_info             (info_in)
  );

  resp_info_fifo #(
    .INFO_DEPTH (INFO_DEPTH)
  ) u_info_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (info_push),
    .i_data  (info_in),
    .i_pop   (info_pop),
    .o_data  (info_head),
    .o_empty (info_empty),
    .o_full  (info_full)
  );

  response_merger u_merger (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_csr_resp_valid  (i_csr_resp_valid),
    .i_csr_resp        (i_csr_resp),
    .o_csr_resp_accept (o_csr_resp_accept),
    .o_mem_resp_valid  (o_mem_resp_valid),
    .o_mem_resp        (o_mem_resp),
    .i_mem_resp_accept (i_mem_resp_accept),
    .i_info            (info_head),
    .i_info_empty      (info_empty),
    .o_info_pop        (info_pop)
  );

endmodule

`default_nettype wire

/* tb_csr_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_slave (
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  input  var logic                  i_cmd_valid,
  input  var csr_bus_pkg::csr_cmd_t i_cmd,
  output logic                      o_cmd_accept,
  output logic                      o_resp_valid,
  output csr_bus_pkg::csr_resp_t    o_resp,
  input  var logic                  i_resp_accept,
  output logic                      o_failed
);

  logic [31:0]            regs [256];
  csr_bus_pkg::csr_cmd_t  exp_cmds [$];
  string                  exp_names [$];
  csr_bus_pkg::csr_resp_t pending [$];  // read data not yet returned.

  task automatic load_word(input logic [7:0] idx, input logic [31:0] value);
    regs[idx] = value;
  endtask

  task automatic expect_cmd(input string name, input csr_bus_pkg::csr_cmd_t cmd);
    exp_names.push_back(name);
    exp_cmds.push_back(cmd);
  endtask

  function automatic int expected_left();
    return exp_cmds.size();
  endfunction

  task automatic check_csr_cmd(input csr_bus_pkg::csr_cmd_t actual);
    csr_bus_pkg::csr_cmd_t expected;
    string                 name;
    if (exp_cmds.size() == 0) begin
      $display("CSR command %h arrived when none was expected", actual);
      o_failed = 1'b1;
    end else begin
      expected = exp_cmds.pop_front();
      name     = exp_names.pop_front();
      if (actual !== expected) begin
        $display("mismatch %s: expected %h actual %h", name, expected, actual);
        o_failed = 1'b1;
      end
    end
  endtask

  task automatic accept_cmd(input csr_bus_pkg::csr_cmd_t cmd);
    logic [7:0]             idx;
    logic [31:0]            mask;
    csr_bus_pkg::csr_resp_t resp;
    check_csr_cmd(cmd);
    idx = cmd.addr[9:2];
    if (cmd.write) begin
      for (int i = 0; i < 4; i++) begin
        mask[8*i +: 8] = {8{cmd.byteen[i]}};
      end
      regs[idx] = (regs[idx] & ~mask) | (cmd.data & mask);
    end else begin
      resp.data  = regs[idx];
      resp.error = cmd.addr[9];  // upper half of the window reports errors.
      pending.push_back(resp);
    end
  endtask

  initial begin
    logic resp_taken;
    o_cmd_accept = 1'b0;
    o_resp_valid = 1'b0;
    o_resp       = '0;
    o_failed     = 1'b0;
    forever begin
      @(posedge i_clk);
      resp_taken = o_resp_valid && i_resp_accept;
      if (i_rst_n && i_cmd_valid && o_cmd_accept) begin
        accept_cmd(i_cmd);
      end
      if (resp_taken) begin
        pending.delete(0);
      end
      #1;
      o_cmd_accept = i_rst_n && ($urandom_range(99) < 65);
      if (resp_taken || !o_resp_valid) begin  // an offered response stays until taken.
        o_resp_valid = (pending.size() > 0) && ($urandom_range(99) < 60);
        if (o_resp_valid) begin
          o_resp = pending[0];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb_membus2csr_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_membus2csr_bridge;

  logic                    clk;
  logic                    rst_n;
  logic                    mem_cmd_valid;
  mem_bus_pkg::mem_cmd_t   mem_cmd;
  logic                    mem_cmd_accept;
  logic                    mem_wdata_valid;
  mem_bus_pkg::mem_wdata_t mem_wdata;
  logic                    mem_wdata_accept;
  logic                    mem_resp_valid;
  mem_bus_pkg::mem_resp_t  mem_resp;
  logic                    mem_resp_accept;
  logic                    csr_cmd_valid;
  csr_bus_pkg::csr_cmd_t   csr_cmd;
  logic                    csr_cmd_accept;
  logic                    csr_resp_valid;
  csr_bus_pkg::csr_resp_t  csr_resp;
  logic                    csr_resp_accept;
  logic                    csr_failed;

  logic [31:0]             model_regs [256];
  mem_bus_pkg::mem_wdata_t wbeats [9];  // enough beats for 16 units at lane offset 1.
  mem_bus_pkg::mem_resp_t  exp_resps [$];
  string                   exp_names [$];

  membus2csr_bridge #(
    .INFO_DEPTH (4)
  ) UUT (
    .i_clk              (clk),
    .i_rst_n            (rst_n),
    .i_mem_cmd_valid    (mem_cmd_valid),
    .i_mem_cmd          (mem_cmd),
    .o_mem_cmd_accept   (mem_cmd_accept),
    .i_mem_wdata_valid  (mem_wdata_valid),
    .i_mem_wdata        (mem_wdata),
    .o_mem_wdata_accept (mem_wdata_accept),
    .o_mem_resp_valid   (mem_resp_valid),
    .o_mem_resp         (mem_resp),
    .i_mem_resp_accept  (mem_resp_accept),
    .o_csr_cmd_valid    (csr_cmd_valid),
    .o_csr_cmd          (csr_cmd),
    .i_csr_cmd_accept   (csr_cmd_accept),
    .i_csr_resp_valid   (csr_resp_valid),
    .i_csr_resp         (csr_resp),
    .o_csr_resp_accept  (csr_resp_accept)
  );

  tb_csr_slave u_slave (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_cmd_valid   (csr_cmd_valid),
    .i_cmd         (csr_cmd),
    .o_cmd_accept  (csr_cmd_accept),
    .o_resp_valid  (csr_resp_valid),
    .o_resp        (csr_resp),
    .i_resp_accept (csr_resp_accept),
    .o_failed      (csr_failed)
  );

  task automatic stop_with_failure(input string reason);
    if (reason.len() > 0) begin
      $display("%s", reason);
    end
    $display("Test FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] fill_word(input int idx);
    return {8'(idx) ^ 8'hc3, 8'(idx), 8'(idx * 7 + 1), ~8'(idx)};
  endfunction

  function automatic logic [7:0] random_byteen();
    logic [3:0] lo;
    logic [3:0] hi;
    lo = ($urandom_range(3) == 0) ? 4'h0 : 4'($urandom);
    hi = ($urandom_range(3) == 0) ? 4'h0 : 4'($urandom);
    return {hi, lo};
  endfunction

  function automatic logic [15:0] unit_addr(input mem_bus_pkg::mem_cmd_t cmd, input int k);
    return {cmd.addr[15:2], 2'b00} + 16'(4 * k);
  endfunction

  task automatic check_mem_resp(input mem_bus_pkg::mem_resp_t actual);
    mem_bus_pkg::mem_resp_t expected;
    string                  name;
    if (exp_resps.size() == 0) begin
      stop_with_failure("a response beat arrived with no read outstanding");
    end else begin
      expected = exp_resps.pop_front();
      name     = exp_names.pop_front();
      if (actual !== expected) begin
        $display("mismatch %s: expected %h actual %h", name, expected, actual);
        stop_with_failure("");
      end
    end
  endtask

  task automatic check_beat_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("mismatch %s: expected %0d beats actual %0d", name, expected, actual);
      stop_with_failure("");
    end
  endtask

  // unit k sits in lane (s+k)%2 of beat (s+k)/2, s being address bit 2.
  task automatic predict_burst(input string name, input mem_bus_pkg::mem_cmd_t cmd);
    csr_bus_pkg::csr_cmd_t  c;
    mem_bus_pkg::mem_resp_t beat;
    logic [15:0]            ua;
    logic [31:0]            mask;
    int                     s;
    int                     len;
    int                     nbeats;
    s      = int'(cmd.addr[2]);
    len    = int'(cmd.length);
    nbeats = (s + len - 1) / 2 + 1;
    for (int k = 0; k < len; k++) begin
      ua = unit_addr(cmd, k);
      c  = '0;
      c.addr = ua;
      if (cmd.kind == mem_bus_pkg::MEM_WRITE) begin
        c.write  = 1'b1;
        c.data   = wbeats[(s + k) / 2].data[32*((s + k) % 2) +: 32];
        c.byteen = wbeats[(s + k) / 2].byteen[4*((s + k) % 2) +: 4];
        if (c.byteen != 4'h0) begin
          for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{c.byteen[i]}};
          end
          model_regs[ua[9:2]] = (model_regs[ua[9:2]] & ~mask) | (c.data & mask);
          u_slave.expect_cmd(name, c);
        end
      end else begin
        u_slave.expect_cmd(name, c);
      end
    end
    if (cmd.kind == mem_bus_pkg::MEM_READ) begin
      for (int b = 0; b < nbeats; b++) begin
        beat      = '0;
        beat.id   = cmd.id;
        beat.last = (b == nbeats - 1);
        for (int k = 0; k < len; k++) begin
          if ((s + k) / 2 == b) begin
            ua = unit_addr(cmd, k);
            beat.data[32*((s + k) % 2) +: 32] = model_regs[ua[9:2]];
            beat.error = beat.error | ua[9];
          end
        end
        exp_resps.push_back(beat);
        exp_names.push_back(name);
      end
    end
  endtask

  task automatic drive_burst(input string name, input mem_bus_pkg::mem_cmd_t cmd);
    int   beat_idx;
    int   nbeats;
    int   cycles;
    logic done;
    beat_idx        = 0;
    nbeats          = (int'(cmd.addr[2]) + int'(cmd.length) - 1) / 2 + 1;
    cycles          = 0;
    done            = 1'b0;
    mem_cmd_valid   = 1'b1;
    mem_cmd         = cmd;
    mem_wdata_valid = (cmd.kind == mem_bus_pkg::MEM_WRITE);
    mem_wdata       = wbeats[0];
    while (!done) begin
      @(posedge clk);
      if (mem_wdata_valid && mem_wdata_accept) begin
        beat_idx++;
      end
      done = mem_cmd_accept;
      cycles++;
      if (cycles > 1000) begin
        stop_with_failure("timeout: the bridge never accepted a memory command");
      end
      #1;
      if (done) begin
        mem_cmd_valid   = 1'b0;
        mem_wdata_valid = 1'b0;
      end else begin
        mem_wdata = wbeats[beat_idx];
      end
    end
    if (cmd.kind == mem_bus_pkg::MEM_WRITE) begin
      check_beat_count(name, nbeats, beat_idx);
    end
  endtask

  task automatic run_burst(input string name, input logic is_write);
    mem_bus_pkg::mem_cmd_t cmd;
    cmd.kind   = is_write ? mem_bus_pkg::MEM_WRITE : mem_bus_pkg::MEM_READ;
    cmd.id     = 4'($urandom);
    cmd.addr   = {6'b0, 8'($urandom), 2'b00};
    cmd.length = 5'($urandom_range(16, 1));
    for (int b = 0; b < 9; b++) begin
      wbeats[b].data   = {$urandom, $urandom};
      wbeats[b].byteen = random_byteen();
    end
    predict_burst(name, cmd);
    drive_burst(name, cmd);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge csr_failed) begin
    stop_with_failure("");
  end

  initial begin
    mem_resp_accept = 1'b0;
    forever begin
      @(posedge clk);
      if (rst_n && mem_resp_valid && mem_resp_accept) begin
        check_mem_resp(mem_resp);
      end
      #1;
      mem_resp_accept = rst_n && ($urandom_range(99) < 70);
    end
  end

  initial begin
    int drain_cycles;
    void'($urandom(51755));
    rst_n           = 1'b0;
    mem_cmd_valid   = 1'b0;
    mem_cmd         = '0;
    mem_wdata_valid = 1'b0;
    mem_wdata       = '0;
    for (int i = 0; i < 256; i++) begin
      model_regs[i] = fill_word(i);
      u_slave.load_word(8'(i), model_regs[i]);
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int n = 0; n < 80; n++) begin
      run_burst("random_burst", 1'($urandom));
    end
    for (int n = 0; n < 6; n++) begin
      run_burst("back_to_back_reads", 1'b0);  // more reads than the FIFO can hold.
    end
    drain_cycles = 0;
    while ((exp_resps.size() != 0 || u_slave.expected_left() != 0) && drain_cycles < 1000) begin
      @(posedge clk);
      drain_cycles++;
    end
    if (exp_resps.size() == 0 && u_slave.expected_left() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      stop_with_failure("timeout: reads or CSR commands still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire

/* sources.f */
mem_bus_pkg.sv
csr_bus_pkg.sv
resp_info_fifo.sv
request_splitter.sv
response_merger.sv
membus2csr_bridge.sv
tb_csr_slave.sv
tb_membus2csr_bridge.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_membus2csr_bridge
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
